/* src/lwc_pkg.sv */
// Shared word types, LWC opcodes and state encodings for the framing wrapper stages
`default_nettype none

package lwc_pkg;

    // Bus and field widths
    typedef logic [31:0] word_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [15:0] seg_len_t;

    // Valid bytes in a word, 0 to 4
    typedef logic [2:0]  byte_cnt_t;

    // Selects one key word, up to 8 of them
    typedef logic [2:0]  key_index_t;

    // Instruction opcodes, found in bits 31 to 28
    localparam opcode_t OP_LDKEY = 4'b0100;
    localparam opcode_t OP_ENC   = 4'b0010;
    localparam opcode_t OP_DEC   = 4'b0011;

    // Segment types of message headers
    localparam opcode_t HDR_PT = 4'b0100;
    localparam opcode_t HDR_CT = 4'b0101;

    // Status word opcode
    localparam opcode_t OP_SUCCESS = 4'b1110;

    // Kind of item moving between pipeline stages
    typedef enum logic {
        ITEM_HEADER,
        ITEM_DATA
    } item_kind_e;

    // Public input parser states
    typedef enum logic [1:0] {
        S_INSTR,
        S_HEADER,
        S_DATA
    } parser_state_e;

    // Secret input states
    typedef enum logic {
        K_IDLE,
        K_LOAD
    } key_state_e;

endpackage

`default_nettype wire

/* src/lwc_key_store.sv */
// Key register bank, filled from the secret-data input after a key-load instruction
`default_nettype none

module lwc_key_store #(
    parameter int KEY_WORDS = 4
) (
    input  wire logic                            clk,
    input  wire logic                            arst_n,
    input  wire lwc_pkg::word_t                  sdi_data,
    input  wire logic                            sdi_valid,
    output lwc_pkg::word_t [KEY_WORDS-1:0]       key_flat
);

    lwc_pkg::key_state_e state;
    lwc_pkg::key_index_t widx;

    // Control side: state and write pointer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= lwc_pkg::K_IDLE;
            widx  <= '0;
        end else if (sdi_valid) begin
            case (state)
                lwc_pkg::K_IDLE: begin
                    if (sdi_data[31:28] == lwc_pkg::OP_LDKEY) begin
                        state <= lwc_pkg::K_LOAD;
                        widx  <= '0;
                    end
                end
                lwc_pkg::K_LOAD: begin
                    if (widx == lwc_pkg::key_index_t'(KEY_WORDS - 1)) begin
                        state <= lwc_pkg::K_IDLE;
                        widx  <= '0;
                    end else begin
                        widx <= widx + 1'b1;
                    end
                end
                default: state <= lwc_pkg::K_IDLE;
            endcase
        end
    end

    // Key words themselves, written in arrival order
    always_ff @(posedge clk) begin
        if (sdi_valid && state == lwc_pkg::K_LOAD) begin
            key_flat[widx] <= sdi_data;
        end
    end

endmodule

`default_nettype wire

/* src/lwc_header_parser.sv */
// First stage: decodes instructions and segment headers, tags each data word with size and last
`default_nettype none

module lwc_header_parser (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire lwc_pkg::word_t      pdi_data,
    input  wire logic                pdi_valid,
    output logic                     p_valid,
    output lwc_pkg::item_kind_e      p_kind,
    output lwc_pkg::word_t           p_word,
    output lwc_pkg::byte_cnt_t       p_size,
    output logic                     p_last,
    output logic                     p_decrypt
);

    lwc_pkg::parser_state_e state;
    lwc_pkg::seg_len_t      remaining;
    logic                   decrypt;

    // Decoded fields of the current input word
    lwc_pkg::opcode_t   opcode;
    lwc_pkg::seg_len_t  hdr_len;
    logic               hdr_empty;
    logic               data_last;
    lwc_pkg::byte_cnt_t data_size;

    always_comb begin
        opcode    = pdi_data[31:28];
        hdr_len   = pdi_data[15:0];
        hdr_empty = (hdr_len == '0);
        data_last = (remaining <= 16'd4);
        // Final word carries what is left, others are full
        if (data_last) begin
            data_size = lwc_pkg::byte_cnt_t'(remaining[2:0]);
        end else begin
            data_size = 3'd4;
        end
    end

    // FSM, length counter and output strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= lwc_pkg::S_INSTR;
            remaining <= '0;
            decrypt   <= 1'b0;
            p_valid   <= 1'b0;
        end else begin
            p_valid <= 1'b0;
            if (pdi_valid) begin
                case (state)
                    lwc_pkg::S_INSTR: begin
                        // Anything but encrypt or decrypt is dropped here
                        if (opcode == lwc_pkg::OP_ENC) begin
                            decrypt <= 1'b0;
                            state   <= lwc_pkg::S_HEADER;
                        end else if (opcode == lwc_pkg::OP_DEC) begin
                            decrypt <= 1'b1;
                            state   <= lwc_pkg::S_HEADER;
                        end
                    end
                    lwc_pkg::S_HEADER: begin
                        p_valid   <= 1'b1;
                        remaining <= hdr_len;
                        if (hdr_empty) begin
                            state <= lwc_pkg::S_INSTR;
                        end else begin
                            state <= lwc_pkg::S_DATA;
                        end
                    end
                    lwc_pkg::S_DATA: begin
                        p_valid <= 1'b1;
                        if (data_last) begin
                            remaining <= '0;
                            state     <= lwc_pkg::S_INSTR;
                        end else begin
                            remaining <= remaining - 16'd4;
                        end
                    end
                    default: state <= lwc_pkg::S_INSTR;
                endcase
            end
        end
    end

    // Item payload, only meaningful while p_valid is high
    always_ff @(posedge clk) begin
        if (pdi_valid && state != lwc_pkg::S_INSTR) begin
            p_word    <= pdi_data;
            p_decrypt <= decrypt;
            if (state == lwc_pkg::S_HEADER) begin
                p_kind <= lwc_pkg::ITEM_HEADER;
                p_size <= '0;
                p_last <= hdr_empty;
            end else begin
                p_kind <= lwc_pkg::ITEM_DATA;
                p_size <= data_size;
                p_last <= data_last;
            end
        end
    end

endmodule

`default_nettype wire

/* src/lwc_stream_xor.sv */
// Second stage: stand-in cipher core, XORs byte-reversed data with the key words in turn
`default_nettype none

module lwc_stream_xor #(
    parameter int KEY_WORDS = 4
) (
    input  wire logic                            clk,
    input  wire logic                            arst_n,
    input  wire logic                            p_valid,
    input  wire lwc_pkg::item_kind_e             p_kind,
    input  wire lwc_pkg::word_t                  p_word,
    input  wire lwc_pkg::byte_cnt_t              p_size,
    input  wire logic                            p_last,
    input  wire logic                            p_decrypt,
    input  wire lwc_pkg::word_t [KEY_WORDS-1:0]  key_flat,
    output logic                                 x_valid,
    output lwc_pkg::item_kind_e                  x_kind,
    output lwc_pkg::word_t                       x_word,
    output lwc_pkg::byte_cnt_t                   x_size,
    output logic                                 x_last,
    output logic                                 x_decrypt
);

    lwc_pkg::key_index_t kidx;
    lwc_pkg::word_t      reversed;
    lwc_pkg::word_t      masked;

    always_comb begin
        // First LWC byte lands in the low byte of the core word
        reversed = {p_word[7:0], p_word[15:8], p_word[23:16], p_word[31:24]};
        masked   = reversed ^ key_flat[kidx];
        // Bytes past the valid count are zeroed
        for (int i = 0; i < 4; i++) begin
            if (lwc_pkg::byte_cnt_t'(i) >= p_size) begin
                masked[8*i +: 8] = 8'h00;
            end
        end
    end

    // Key word pointer, restarted by every header
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kidx    <= '0;
            x_valid <= 1'b0;
        end else begin
            x_valid <= p_valid;
            if (p_valid) begin
                if (p_kind == lwc_pkg::ITEM_HEADER) begin
                    kidx <= '0;
                end else if (kidx == lwc_pkg::key_index_t'(KEY_WORDS - 1)) begin
                    kidx <= '0;
                end else begin
                    kidx <= kidx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (p_valid) begin
            x_kind    <= p_kind;
            x_size    <= p_size;
            x_last    <= p_last;
            x_decrypt <= p_decrypt;
            if (p_kind == lwc_pkg::ITEM_HEADER) begin
                x_word <= p_word;
            end else begin
                x_word <= masked;
            end
        end
    end

endmodule

`default_nettype wire

/* src/lwc_output_formatter.sv */
// Third stage: builds the output segment header, restores byte order and appends the status word
`default_nettype none

module lwc_output_formatter (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                x_valid,
    input  wire lwc_pkg::item_kind_e x_kind,
    input  wire lwc_pkg::word_t      x_word,
    input  wire lwc_pkg::byte_cnt_t  x_size,
    input  wire logic                x_last,
    input  wire logic                x_decrypt,
    output lwc_pkg::word_t           do_data,
    output logic                     do_valid,
    output logic                     do_last
);

    logic              pending;
    logic              eot;
    lwc_pkg::seg_len_t seg_len;
    lwc_pkg::word_t    out_header;
    lwc_pkg::word_t    restored;
    lwc_pkg::word_t    status_word;

    always_comb begin
        eot     = x_word[25];
        seg_len = x_word[15:0];
        // Decrypt output is plaintext, end-of-type also marks the last segment
        if (x_decrypt) begin
            out_header = {lwc_pkg::HDR_PT, 2'b00, eot, eot, 8'h00, seg_len};
        end else begin
            out_header = {lwc_pkg::HDR_CT, 2'b00, eot, 1'b0, 8'h00, seg_len};
        end
        restored    = {x_word[7:0], x_word[15:8], x_word[23:16], x_word[31:24]};
        status_word = {lwc_pkg::OP_SUCCESS, 28'h0};
    end

    // Strobes and the pending status flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending  <= 1'b0;
            do_valid <= 1'b0;
            do_last  <= 1'b0;
        end else if (x_valid) begin
            do_valid <= 1'b1;
            do_last  <= 1'b0;
            pending  <= x_last;
        end else if (pending) begin
            // Status follows one cycle after the final item
            do_valid <= 1'b1;
            do_last  <= 1'b1;
            pending  <= 1'b0;
        end else begin
            do_valid <= 1'b0;
            do_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (x_valid) begin
            if (x_kind == lwc_pkg::ITEM_HEADER) begin
                do_data <= out_header;
            end else begin
                // Size already applied by the masking stage
                do_data <= restored;
            end
        end else if (pending) begin
            do_data <= status_word;
        end
    end

endmodule

`default_nettype wire

/* src/lwc_top.sv */
// Top level of the framing wrapper, ties the key store to the three-stage pipeline
`default_nettype none

module lwc_top #(
    parameter int KEY_WORDS = 4
) (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire lwc_pkg::word_t pdi_data,
    input  wire logic           pdi_valid,
    input  wire lwc_pkg::word_t sdi_data,
    input  wire logic           sdi_valid,
    output lwc_pkg::word_t      do_data,
    output logic                do_valid,
    output logic                do_last
);

    lwc_pkg::word_t [KEY_WORDS-1:0] key_flat;

    // Parser to XOR stage
    logic                p_valid;
    lwc_pkg::item_kind_e p_kind;
    lwc_pkg::word_t      p_word;
    lwc_pkg::byte_cnt_t  p_size;
    logic                p_last;
    logic                p_decrypt;

    // XOR stage to formatter
    logic                x_valid;
    lwc_pkg::item_kind_e x_kind;
    lwc_pkg::word_t      x_word;
    lwc_pkg::byte_cnt_t  x_size;
    logic                x_last;
    logic                x_decrypt;

    lwc_key_store #(
        .KEY_WORDS (KEY_WORDS)
    ) u_key_store (
        .clk       (clk),
        .arst_n    (arst_n),
        .sdi_data  (sdi_data),
        .sdi_valid (sdi_valid),
        .key_flat  (key_flat)
    );

    lwc_header_parser u_parser (
        .clk       (clk),
        .arst_n    (arst_n),
        .pdi_data  (pdi_data),
        .pdi_valid (pdi_valid),
        .p_valid   (p_valid),
        .p_kind    (p_kind),
        .p_word    (p_word),
        .p_size    (p_size),
        .p_last    (p_last),
        .p_decrypt (p_decrypt)
    );

    lwc_stream_xor #(
        .KEY_WORDS (KEY_WORDS)
    ) u_stream_xor (
        .clk       (clk),
        .arst_n    (arst_n),
        .p_valid   (p_valid),
        .p_kind    (p_kind),
        .p_word    (p_word),
        .p_size    (p_size),
        .p_last    (p_last),
        .p_decrypt (p_decrypt),
        .key_flat  (key_flat),
        .x_valid   (x_valid),
        .x_kind    (x_kind),
        .x_word    (x_word),
        .x_size    (x_size),
        .x_last    (x_last),
        .x_decrypt (x_decrypt)
    );

    lwc_output_formatter u_formatter (
        .clk       (clk),
        .arst_n    (arst_n),
        .x_valid   (x_valid),
        .x_kind    (x_kind),
        .x_word    (x_word),
        .x_size    (x_size),
        .x_last    (x_last),
        .x_decrypt (x_decrypt),
        .do_data   (do_data),
        .do_valid  (do_valid),
        .do_last   (do_last)
    );

endmodule

`default_nettype wire

/* tests/lwc_properties.sv */
// Output strobe assertions, bound into every lwc_top instance during simulation
`default_nettype none

module lwc_properties (
    input wire logic           clk,
    input wire logic           arst_n,
    input wire lwc_pkg::word_t do_data,
    input wire logic           do_valid,
    input wire logic           do_last
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failure count, read by the testbench at the end of the run
    int assert_failures = 0;

    last_with_valid: assert property (@(posedge clk) disable iff (!arst_n) do_last |-> do_valid)
        else begin
            $error("do_last high without do_valid");
            assert_failures++;
        end

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !do_valid)
        else begin
            $error("do_valid high while arst_n is low");
            assert_failures++;
        end

    // Only the status word closes a message
    last_is_status: assert property (@(posedge clk) disable iff (!arst_n)
        do_last |-> do_data[31:28] == lwc_pkg::OP_SUCCESS)
        else begin
            $error("do_last on a word that is not a status word");
            assert_failures++;
        end

endmodule

bind lwc_top lwc_properties u_props (
    .clk      (clk),
    .arst_n   (arst_n),
    .do_data  (do_data),
    .do_valid (do_valid),
    .do_last  (do_last)
);

`default_nettype wire

/* tests/lwc_tb.sv */
// Self-checking testbench for the LWC framing wrapper, simulated with lwc_tb as top module
`default_nettype none

module lwc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int KEY_WORDS   = 4;
    localparam int KIND_HEADER = 0;
    localparam int KIND_DATA   = 1;
    localparam int KIND_STATUS = 2;
    localparam int TIMEOUT     = 200;

    logic           clk = 1'b0;
    logic           arst_n;
    lwc_pkg::word_t pdi_data;
    logic           pdi_valid;
    lwc_pkg::word_t sdi_data;
    logic           sdi_valid;
    lwc_pkg::word_t do_data;
    logic           do_valid;
    logic           do_last;

    lwc_pkg::word_t key_model [KEY_WORDS];
    lwc_pkg::word_t msg [16];
    lwc_pkg::word_t captured [32];
    int             cap_count;
    int             cycle_count = 0;
    string          test_name;

    // Expected outputs in arrival order
    lwc_pkg::word_t exp_word [$];
    logic           exp_last [$];
    int             exp_cycle [$];

    lwc_top #(
        .KEY_WORDS (KEY_WORDS)
    ) uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .pdi_data  (pdi_data),
        .pdi_valid (pdi_valid),
        .sdi_data  (sdi_data),
        .sdi_valid (sdi_valid),
        .do_data   (do_data),
        .do_valid  (do_valid),
        .do_last   (do_last)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic lwc_pkg::word_t expected_word(input int kind, input lwc_pkg::word_t in_word,
            input logic decrypt, input lwc_pkg::byte_cnt_t size, input lwc_pkg::word_t key_word);
        lwc_pkg::word_t result;
        result = '0;
        if (kind == KIND_STATUS) begin
            result[31:28] = lwc_pkg::OP_SUCCESS;
        end else if (kind == KIND_HEADER) begin
            result[31:28] = decrypt ? lwc_pkg::HDR_PT : lwc_pkg::HDR_CT;
            result[25]    = in_word[25];
            result[24]    = decrypt & in_word[25];
            result[15:0]  = in_word[15:0];
        end else begin
            // Core works on reversed bytes, so the key shows up swapped here
            result = in_word ^ {key_word[7:0], key_word[15:8], key_word[23:16], key_word[31:24]};
            for (int j = 0; j < 4; j++) begin
                if (j >= int'(size)) begin
                    result[31-8*j -: 8] = 8'h00;
                end
            end
        end
        return result;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_word(input string what, input lwc_pkg::word_t expected,
            input lwc_pkg::word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s: %s expected %h actual %h",
                test_name, what, expected, actual));
        end
    endtask

    task automatic check_last(input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s: do_last expected %b actual %b",
                test_name, expected, actual));
        end
    endtask

    task automatic check_cycle(input int expected, input int actual);
        if (actual != expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s: output cycle expected %0d actual %0d",
                test_name, expected, actual));
        end
    endtask

    task automatic push_expected(input lwc_pkg::word_t w, input logic last, input int due);
        exp_word.push_back(w);
        exp_last.push_back(last);
        exp_cycle.push_back(due);
    endtask

    task automatic drive_word(input lwc_pkg::word_t w);
        @(posedge clk);
        pdi_data  <= w;
        pdi_valid <= 1'b1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_word.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_word.size() != 0) begin
            stop_with_failure($sformatf("Timeout in %s: %0d expected output words never came",
                test_name, exp_word.size()));
        end
    endtask

    task automatic load_key(input logic random_key);
        wait_drain();
        @(posedge clk);
        sdi_data  <= {lwc_pkg::OP_LDKEY, 28'h0};
        sdi_valid <= 1'b1;
        for (int k = 0; k < KEY_WORDS; k++) begin
            key_model[k] = random_key ? $urandom() : 32'h0123_4567 + k * 32'h1357_9bdf;
            @(posedge clk);
            sdi_data <= key_model[k];
        end
        @(posedge clk);
        sdi_valid <= 1'b0;
    endtask

    task automatic send_message(input logic decrypt, input logic eot, input int len,
            input logic [7:0] noise);
        lwc_pkg::word_t     header;
        lwc_pkg::byte_cnt_t size;
        int                 due;
        header = {decrypt ? lwc_pkg::HDR_CT : lwc_pkg::HDR_PT, 2'b00, eot, 1'b0, noise, 16'(len)};
        cap_count = 0;
        drive_word({decrypt ? lwc_pkg::OP_DEC : lwc_pkg::OP_ENC, 28'h0});
        drive_word(header);
        // Strobe sits in the cycle after this edge, output 3 cycles after that
        due = cycle_count + 4;
        push_expected(expected_word(KIND_HEADER, header, decrypt, 0, '0), 1'b0, due);
        for (int i = 0; i < (len + 3) / 4; i++) begin
            size = (len - 4 * i >= 4) ? 3'd4 : lwc_pkg::byte_cnt_t'(len - 4 * i);
            drive_word(msg[i]);
            due = cycle_count + 4;
            push_expected(expected_word(KIND_DATA, msg[i], decrypt, size,
                key_model[i % KEY_WORDS]), 1'b0, due);
        end
        push_expected(expected_word(KIND_STATUS, '0, decrypt, 0, '0), 1'b1, due + 1);
        @(posedge clk);
        pdi_valid <= 1'b0;
    endtask

    // Compare on the falling edge, away from the DUT's register updates
    always @(negedge clk) begin
        if (do_valid) begin
            if (exp_word.size() == 0) begin
                stop_with_failure($sformatf("Output word %h appeared in %s with nothing expected",
                    do_data, test_name));
            end else begin
                check_cycle(exp_cycle.pop_front(), cycle_count);
                check_word("output word", exp_word.pop_front(), do_data);
                check_last(exp_last.pop_front(), do_last);
                if (cap_count < 32) begin
                    captured[cap_count] = do_data;
                end
                cap_count++;
            end
        end
    end

    initial begin
        int len;
        pdi_data  = '0;
        pdi_valid = 1'b0;
        sdi_data  = '0;
        sdi_valid = 1'b0;
        arst_n    = 1'b1;
        cap_count = 0;
        test_name = "reset";
        void'($urandom(4625));
        #1;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        test_name = "encrypt_16_bytes";
        load_key(1'b0);
        for (int i = 0; i < 4; i++) begin
            msg[i] = 32'h3322_1100 + i * 32'h4444_4444;
        end
        send_message(1'b0, 1'b1, 16, 8'h00);
        wait_drain();

        test_name = "decrypt_round_trip";
        for (int i = 0; i < 4; i++) begin
            msg[i] = captured[i + 1];
        end
        send_message(1'b1, 1'b1, 16, 8'h00);
        wait_drain();
        check_word("decrypt header flags", 32'h0300_0000, captured[0] & 32'h0300_0000);
        for (int i = 0; i < 4; i++) begin
            check_word("restored plaintext", 32'h3322_1100 + i * 32'h4444_4444, captured[i + 1]);
        end

        test_name = "partial_7_bytes";
        msg[0] = 32'hdead_beef;
        msg[1] = 32'hcafe_f00d;
        send_message(1'b0, 1'b0, 7, 8'h00);
        wait_drain();
        check_word("masked low byte", 32'h0, captured[2] & 32'h0000_00ff);

        test_name = "zero_length";
        send_message(1'b0, 1'b1, 0, 8'h00);
        wait_drain();
        if (cap_count != 2) begin
            stop_with_failure("Zero-length segment did not give exactly a header and a status");
        end

        test_name = "unknown_opcode";
        drive_word({4'b0111, 28'h0});
        drive_word({4'b1111, 28'h0123});
        @(posedge clk);
        pdi_valid <= 1'b0;
        repeat (8) @(posedge clk);

        test_name = "random_messages";
        for (int m = 0; m < 20; m++) begin
            if ($urandom_range(3, 0) == 0) begin
                load_key(1'b1);
            end
            len = $urandom_range(40, 0);
            for (int i = 0; i < 10; i++) begin
                msg[i] = $urandom();
            end
            send_message(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)), len,
                8'($urandom()));
            repeat ($urandom_range(2, 0)) @(posedge clk);
        end
        wait_drain();
        repeat (4) @(posedge clk);

        if (uut.u_props.assert_failures == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_failure("Output protocol assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

/* project.f */
src/lwc_pkg.sv
src/lwc_key_store.sv
src/lwc_header_parser.sv
src/lwc_stream_xor.sv
src/lwc_output_formatter.sv
src/lwc_top.sv
tests/lwc_properties.sv
tests/lwc_tb.sv
